// ==== verilog/mmc1_pkg.sv ====
package mmc1_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int reg_width      = 5;
    localparam int sst_addr_width = 3;
    localparam int prg_sel_width  = 4;   // 16 KiB bank number.
    localparam int chr_sel_width  = 5;   // 4 KiB bank number.
    localparam int prg_page_bits  = 14;
    localparam int chr_page_bits  = 12;
    localparam int wram_addr_bits = 13;

    ////////////////////////////////////////////////////////////////////////////
    // save-state map
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [sst_addr_width-1:0] sst_shift   = 3'd0;
    localparam logic [sst_addr_width-1:0] sst_control = 3'd1;
    localparam logic [sst_addr_width-1:0] sst_chr0    = 3'd2;
    localparam logic [sst_addr_width-1:0] sst_chr1    = 3'd3;
    localparam logic [sst_addr_width-1:0] sst_prg     = 3'd4;

    localparam logic [7:0] sst_none_value = 8'hff;

    ////////////////////////////////////////////////////////////////////////////
    // reset values and codes
    ////////////////////////////////////////////////////////////////////////////

    // marker bit walks down to bit 0 after four shifts.
    localparam logic [reg_width-1:0] shift_reset_value   = 5'b10000;
    localparam logic [reg_width-1:0] control_reset_value = 5'b01100;

    // control[1:0].
    localparam logic [1:0] mirror_one_low    = 2'd0;
    localparam logic [1:0] mirror_one_high   = 2'd1;
    localparam logic [1:0] mirror_vertical   = 2'd2;
    localparam logic [1:0] mirror_horizontal = 2'd3;

    // codes 0 and 1 of control[3:2] both switch 32 KiB.
    localparam logic [1:0] prg_mode_32k       = 2'd0;
    localparam logic [1:0] prg_mode_fix_first = 2'd2;
    localparam logic [1:0] prg_mode_fix_last  = 2'd3;

endpackage

// ==== verilog/mmc1_regs.sv ====
`timescale 1ns/1ps

module mmc1_regs (
    input  logic                                 m2,
    input  logic                                 reset,
    input  logic [15:0]                          cpu_addr,
    input  logic                                 cpu_rw,
    input  logic [7:0]                           cpu_data_in,
    input  logic                                 sst_enable,
    input  logic                                 sst_we,
    input  logic [mmc1_pkg::sst_addr_width-1:0]  sst_addr,
    input  logic [7:0]                           sst_data_in,
    output logic [7:0]                           sst_data_out,
    output logic [mmc1_pkg::reg_width-1:0]       control,
    output logic [mmc1_pkg::reg_width-1:0]       chr_bank_0,
    output logic [mmc1_pkg::reg_width-1:0]       chr_bank_1,
    output logic [mmc1_pkg::reg_width-1:0]       prg_bank
);

    localparam logic [mmc1_pkg::reg_width-1:0] fix_last_bits =
        {1'b0, mmc1_pkg::prg_mode_fix_last, 2'b00};

    logic [mmc1_pkg::reg_width-1:0] shift;
    logic [mmc1_pkg::reg_width-1:0] shift_next;
    logic [mmc1_pkg::reg_width-1:0] sst_value;
    logic                           cpu_write;
    logic                           sst_write;
    logic                           load_reset;
    logic                           load_done;

    assign cpu_write  = cpu_addr[15] && !cpu_rw;   // any write to $8000-$FFFF.
    assign sst_write  = sst_enable && sst_we;
    assign load_reset = cpu_data_in[7];
    assign load_done  = shift[0];                  // marker reached the bottom.

    // serial data enters at the top.
    assign shift_next = {cpu_data_in[0], shift[mmc1_pkg::reg_width-1:1]};
    assign sst_value  = sst_data_in[mmc1_pkg::reg_width-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // load register and mapper registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(negedge m2) begin
        if (reset) begin
            shift      <= mmc1_pkg::shift_reset_value;
            control    <= mmc1_pkg::control_reset_value;
            chr_bank_0 <= '0;
            chr_bank_1 <= '0;
            prg_bank   <= '0;
        end else if (sst_enable) begin
            if (sst_write) begin
                case (sst_addr)
                    mmc1_pkg::sst_shift:   shift      <= sst_value;
                    mmc1_pkg::sst_control: control    <= sst_value;
                    mmc1_pkg::sst_chr0:    chr_bank_0 <= sst_value;
                    mmc1_pkg::sst_chr1:    chr_bank_1 <= sst_value;
                    mmc1_pkg::sst_prg:     prg_bank   <= sst_value;
                    default: begin
                        shift <= shift;   // unused slots ignore writes.
                    end
                endcase
            end
        end else if (cpu_write) begin
            if (load_reset) begin
                shift   <= mmc1_pkg::shift_reset_value;
                control <= control | fix_last_bits;   // back to fix-last mode.
            end else if (load_done) begin
                case (cpu_addr[14:13])
                    2'd0: control    <= shift_next;
                    2'd1: chr_bank_0 <= shift_next;
                    2'd2: chr_bank_1 <= shift_next;
                    2'd3: prg_bank   <= shift_next;
                endcase
                shift <= mmc1_pkg::shift_reset_value;
            end else begin
                shift <= shift_next;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // save-state readback
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (sst_addr)
            mmc1_pkg::sst_shift:   sst_data_out = 8'(shift);
            mmc1_pkg::sst_control: sst_data_out = 8'(control);
            mmc1_pkg::sst_chr0:    sst_data_out = 8'(chr_bank_0);
            mmc1_pkg::sst_chr1:    sst_data_out = 8'(chr_bank_1);
            mmc1_pkg::sst_prg:     sst_data_out = 8'(prg_bank);
            default:               sst_data_out = mmc1_pkg::sst_none_value;
        endcase
    end

endmodule

// ==== verilog/mmc1_prg_map.sv ====
`timescale 1ns/1ps

module mmc1_prg_map #(
    parameter int addr_bits = 20
) (
    input  logic [15:0]                    cpu_addr,
    input  logic                           cpu_rw,
    input  logic [1:0]                     prg_mode,
    input  logic [mmc1_pkg::reg_width-1:0] prg_bank,
    input  logic                           prg_outer,
    output logic [addr_bits-1:0]           prg_addr,
    output logic                           prg_oe,
    output logic                           prg_we,
    output logic                           wram_ce
);

    logic [mmc1_pkg::prg_sel_width-1:0] prg_sel;
    logic [mmc1_pkg::prg_sel_width-1:0] bank_low;
    logic                               upper_half;
    logic                               wram_window;

    assign upper_half  = cpu_addr[14];                     // $C000-$FFFF.
    assign bank_low    = prg_bank[mmc1_pkg::prg_sel_width-1:0];
    assign wram_window = (cpu_addr[15:13] == 3'b011);      // $6000-$7FFF.

    // bit 4 of prg_bank disables work RAM.
    assign wram_ce = wram_window && !prg_bank[4];

    ////////////////////////////////////////////////////////////////////////////
    // 16 KiB bank select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (prg_mode[1] == mmc1_pkg::prg_mode_32k[1]) begin
            prg_sel = {bank_low[mmc1_pkg::prg_sel_width-1:1], upper_half};
        end else if (prg_mode == mmc1_pkg::prg_mode_fix_first) begin
            prg_sel = upper_half ? bank_low : '0;
        end else begin
            prg_sel = upper_half ? '1 : bank_low;   // last bank at $C000.
        end
    end

    always_comb begin
        if (wram_ce) begin
            prg_addr = addr_bits'(cpu_addr[mmc1_pkg::wram_addr_bits-1:0]);
        end else begin
            prg_addr = addr_bits'({prg_outer, prg_sel,
                                   cpu_addr[mmc1_pkg::prg_page_bits-1:0]});
        end
    end

    assign prg_oe = cpu_rw && (cpu_addr[15] || wram_ce);
    assign prg_we = !cpu_rw && wram_ce;   // ROM is never written.

endmodule

// ==== verilog/mmc1_chr_map.sv ====
`timescale 1ns/1ps

module mmc1_chr_map #(
    parameter int addr_bits = 20
) (
    input  logic [13:0]                    ppu_addr,
    input  logic                           ppu_rd,
    input  logic                           ppu_wr,
    input  logic                           chr_ram,
    input  logic                           chr_mode,
    input  logic [1:0]                     mirror,
    input  logic [mmc1_pkg::reg_width-1:0] chr_bank_0,
    input  logic [mmc1_pkg::reg_width-1:0] chr_bank_1,
    output logic [addr_bits-1:0]           chr_addr,
    output logic                           chr_oe,
    output logic                           chr_we,
    output logic                           ciram_ce,
    output logic                           ciram_a10,
    output logic                           prg_outer
);

    logic [mmc1_pkg::chr_sel_width-1:0] chr_sel;
    logic                               upper_half;

    assign upper_half = ppu_addr[12];   // $1000-$1FFF.

    ////////////////////////////////////////////////////////////////////////////
    // 4 KiB bank select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (!chr_mode) begin
            chr_sel = {chr_bank_0[mmc1_pkg::chr_sel_width-1:1], upper_half};   // 8 KiB.
        end else if (upper_half) begin
            chr_sel = chr_bank_1;
        end else begin
            chr_sel = chr_bank_0;
        end
    end

    // SUROM uses the top CHR bit as PRG A18.
    assign prg_outer = chr_sel[mmc1_pkg::chr_sel_width-1];

    always_comb begin
        if (chr_ram) begin
            chr_addr = addr_bits'(ppu_addr[12:0]);   // 8 KiB RAM, no banking.
        end else begin
            chr_addr = addr_bits'({chr_sel, ppu_addr[mmc1_pkg::chr_page_bits-1:0]});
        end
    end

    assign chr_oe   = !ppu_rd;
    assign chr_we   = chr_ram && !ppu_wr;
    assign ciram_ce = !ppu_addr[13];

    // nametable mirroring.
    always_comb begin
        case (mirror)
            mmc1_pkg::mirror_one_low:    ciram_a10 = 1'b0;
            mmc1_pkg::mirror_one_high:   ciram_a10 = 1'b1;
            mmc1_pkg::mirror_vertical:   ciram_a10 = ppu_addr[10];
            mmc1_pkg::mirror_horizontal: ciram_a10 = ppu_addr[11];
            default:                     ciram_a10 = 1'b0;
        endcase
    end

endmodule

// ==== verilog/mapper_mmc1.sv ====
`timescale 1ns/1ps

module mapper_mmc1 #(
    parameter int addr_bits = 20
) (
    input  logic                                 m2,
    input  logic                                 reset,

    // cpu bus.
    input  logic [15:0]                          cpu_addr,
    input  logic                                 cpu_rw,
    input  logic [7:0]                           cpu_data_in,
    output logic [addr_bits-1:0]                 prg_addr,
    output logic                                 prg_oe,
    output logic                                 prg_we,
    output logic                                 wram_ce,

    // ppu bus.
    input  logic [13:0]                          ppu_addr,
    input  logic                                 ppu_rd,
    input  logic                                 ppu_wr,
    input  logic                                 chr_ram,
    output logic [addr_bits-1:0]                 chr_addr,
    output logic                                 chr_oe,
    output logic                                 chr_we,
    output logic                                 ciram_ce,
    output logic                                 ciram_a10,

    // save state.
    input  logic                                 sst_enable,
    input  logic                                 sst_we,
    input  logic [mmc1_pkg::sst_addr_width-1:0]  sst_addr,
    input  logic [7:0]                           sst_data_in,
    output logic [7:0]                           sst_data_out
);

    logic [mmc1_pkg::reg_width-1:0] control;
    logic [mmc1_pkg::reg_width-1:0] chr_bank_0;
    logic [mmc1_pkg::reg_width-1:0] chr_bank_1;
    logic [mmc1_pkg::reg_width-1:0] prg_bank;
    logic                           prg_outer;   // from chr side.

    ////////////////////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////////////////////

    mmc1_regs i_regs (
        .m2           (m2),
        .reset        (reset),
        .cpu_addr     (cpu_addr),
        .cpu_rw       (cpu_rw),
        .cpu_data_in  (cpu_data_in),
        .sst_enable   (sst_enable),
        .sst_we       (sst_we),
        .sst_addr     (sst_addr),
        .sst_data_in  (sst_data_in),
        .sst_data_out (sst_data_out),
        .control      (control),
        .chr_bank_0   (chr_bank_0),
        .chr_bank_1   (chr_bank_1),
        .prg_bank     (prg_bank)
    );

    ////////////////////////////////////////////////////////////////////////////
    // translators
    ////////////////////////////////////////////////////////////////////////////

    mmc1_prg_map #(
        .addr_bits (addr_bits)
    ) i_prg (
        .cpu_addr  (cpu_addr),
        .cpu_rw    (cpu_rw),
        .prg_mode  (control[3:2]),
        .prg_bank  (prg_bank),
        .prg_outer (prg_outer),
        .prg_addr  (prg_addr),
        .prg_oe    (prg_oe),
        .prg_we    (prg_we),
        .wram_ce   (wram_ce)
    );

    mmc1_chr_map #(
        .addr_bits (addr_bits)
    ) i_chr (
        .ppu_addr   (ppu_addr),
        .ppu_rd     (ppu_rd),
        .ppu_wr     (ppu_wr),
        .chr_ram    (chr_ram),
        .chr_mode   (control[4]),
        .mirror     (control[1:0]),
        .chr_bank_0 (chr_bank_0),
        .chr_bank_1 (chr_bank_1),
        .chr_addr   (chr_addr),
        .chr_oe     (chr_oe),
        .chr_we     (chr_we),
        .ciram_ce   (ciram_ce),
        .ciram_a10  (ciram_a10),
        .prg_outer  (prg_outer)
    );

endmodule

// ==== tb/mmc1_model.svh ====
`ifndef MMC1_MODEL_SVH
`define MMC1_MODEL_SVH

// shadow copy of the mapper registers.
logic [4:0]  shadow_control;
logic [4:0]  shadow_chr0;
logic [4:0]  shadow_chr1;
logic [4:0]  shadow_prg;
logic [31:0] rng_state = 32'd23826;

function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

function automatic logic expect_wram(input logic [15:0] a);
    return (a >= 16'h6000) && (a <= 16'h7fff) && !shadow_prg[4];
endfunction

// top bit of whichever chr bank covers this ppu address.
function automatic logic expect_outer(input logic [13:0] p);
    if (shadow_control[4])
        return p[12] ? shadow_chr1[4] : shadow_chr0[4];
    return shadow_chr0[4];
endfunction

function automatic logic [19:0] expect_prg_addr(input logic [15:0] a, input logic [13:0] p);
    logic [3:0] bank;
    if (expect_wram(a))
        return 20'(a[12:0]);
    case (shadow_control[3:2])
        2'b00, 2'b01: bank = {shadow_prg[3:1], a[14]};
        2'b10:        bank = a[14] ? shadow_prg[3:0] : 4'h0;
        default:      bank = a[14] ? 4'hf : shadow_prg[3:0];
    endcase
    return {1'b0, expect_outer(p), bank, a[13:0]};
endfunction

function automatic logic [19:0] expect_chr_addr(input logic [13:0] p, input logic ram);
    logic [4:0] bank;
    if (ram)
        return 20'(p[12:0]);
    if (shadow_control[4])
        bank = p[12] ? shadow_chr1 : shadow_chr0;
    else
        bank = {shadow_chr0[4:1], p[12]};
    return {3'b000, bank, p[11:0]};
endfunction

function automatic logic expect_a10(input logic [13:0] p);
    case (shadow_control[1:0])
        2'd0:    return 1'b0;
        2'd1:    return 1'b1;
        2'd2:    return p[10];
        default: return p[11];
    endcase
endfunction

`endif

// ==== tb/mapper_mmc1_tb.sv ====
`timescale 1ns/1ps

module mapper_mmc1_tb;

    localparam int addr_bits        = 20;
    localparam int clock_period     = 20;
    localparam int reset_cycles     = 8;
    localparam int samples          = 16;
    localparam int write_reg_cycles = 10;   // five writes, two cycles each.
    localparam int test_cycles      = reset_cycles + 40 * write_reg_cycles + 12 * samples + 100;
    localparam int timeout_ns       = (test_cycles + 200) * clock_period;

    logic                 m2;
    logic                 reset;
    logic [15:0]          cpu_addr;
    logic                 cpu_rw;
    logic [7:0]           cpu_data_in;
    logic [addr_bits-1:0] prg_addr;
    logic                 prg_oe;
    logic                 prg_we;
    logic                 wram_ce;
    logic [13:0]          ppu_addr;
    logic                 ppu_rd;
    logic                 ppu_wr;
    logic                 chr_ram;
    logic [addr_bits-1:0] chr_addr;
    logic                 chr_oe;
    logic                 chr_we;
    logic                 ciram_ce;
    logic                 ciram_a10;
    logic                 sst_enable;
    logic                 sst_we;
    logic [2:0]           sst_addr;
    logic [7:0]           sst_data_in;
    logic [7:0]           sst_data_out;

    `include "mmc1_model.svh"

    mapper_mmc1 #(.addr_bits(addr_bits)) i_dut (
        .m2(m2), .reset(reset),
        .cpu_addr(cpu_addr), .cpu_rw(cpu_rw), .cpu_data_in(cpu_data_in),
        .prg_addr(prg_addr), .prg_oe(prg_oe), .prg_we(prg_we), .wram_ce(wram_ce),
        .ppu_addr(ppu_addr), .ppu_rd(ppu_rd), .ppu_wr(ppu_wr), .chr_ram(chr_ram),
        .chr_addr(chr_addr), .chr_oe(chr_oe), .chr_we(chr_we),
        .ciram_ce(ciram_ce), .ciram_a10(ciram_a10),
        .sst_enable(sst_enable), .sst_we(sst_we), .sst_addr(sst_addr),
        .sst_data_in(sst_data_in), .sst_data_out(sst_data_out)
    );

    initial begin
        m2 = 1'b0;
        forever #(clock_period / 2) m2 = ~m2;
    end

    initial begin
        #(timeout_ns);
        $display("timeout: the tests did not finish within %0d ns", timeout_ns);
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////////////////////
    // bus helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("Something failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic to_drive_point();
        @(posedge m2);
        #2;
    endtask

    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        to_drive_point();
        cpu_addr    = addr;
        cpu_rw      = 1'b0;
        cpu_data_in = data;
        to_drive_point();
        cpu_rw      = 1'b1;
        cpu_data_in = 8'h00;
    endtask

    // five serial writes, lsb first, with junk in bits 6:1.
    task automatic write_reg(input int index, input logic [4:0] value);
        logic [15:0] addr;
        logic [31:0] r;
        addr = 16'h8000 + 16'(index) * 16'h2000;
        for (int i = 0; i < 5; i++) begin
            r = next_random();
            cpu_write(addr, {1'b0, r[6:1], value[i]});
        end
        case (index)
            0:       shadow_control = value;
            1:       shadow_chr0    = value;
            2:       shadow_chr1    = value;
            default: shadow_prg     = value;
        endcase
    endtask

    task automatic sst_write(input logic [2:0] addr, input logic [4:0] value);
        to_drive_point();
        sst_enable  = 1'b1;
        sst_we      = 1'b1;
        sst_addr    = addr;
        sst_data_in = {3'b000, value};
        cpu_addr    = 16'he000;   // competing cpu write.
        cpu_rw      = 1'b0;
        cpu_data_in = 8'(next_random());
        to_drive_point();
        sst_enable  = 1'b0;
        sst_we      = 1'b0;
        cpu_rw      = 1'b1;
    endtask

    task automatic check_sst(input logic [2:0] addr, input logic [7:0] expected,
                             input string what);
        to_drive_point();
        sst_addr = addr;
        #3;
        check_value(what, sst_data_out, expected);
    endtask

    task automatic check_registers(input logic [7:0] shift_expected);
        check_sst(mmc1_pkg::sst_shift, shift_expected, "shift readback");
        check_sst(mmc1_pkg::sst_control, {3'b000, shadow_control}, "control readback");
        check_sst(mmc1_pkg::sst_chr0, {3'b000, shadow_chr0}, "chr0 readback");
        check_sst(mmc1_pkg::sst_chr1, {3'b000, shadow_chr1}, "chr1 readback");
        check_sst(mmc1_pkg::sst_prg, {3'b000, shadow_prg}, "prg readback");
    endtask

    // compare both translators at a random cpu and ppu address.
    task automatic check_translation();
        to_drive_point();
        cpu_addr = 16'(next_random());
        cpu_rw   = 1'b1;
        ppu_addr = 14'(next_random());
        #3;
        check_value("prg_addr", prg_addr, expect_prg_addr(cpu_addr, ppu_addr));
        check_value("prg_oe", prg_oe, cpu_addr[15] || expect_wram(cpu_addr));
        check_value("wram_ce", wram_ce, expect_wram(cpu_addr));
        check_value("chr_addr", chr_addr, expect_chr_addr(ppu_addr, chr_ram));
        check_value("ciram_a10", ciram_a10, expect_a10(ppu_addr));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        check_registers(8'h10);
        for (int a = 5; a < 8; a++)
            check_sst(3'(a), 8'hff, "unused save-state slot");
        to_drive_point();
        cpu_addr = 16'h8000;
        ppu_addr = 14'h0000;
        #3;
        check_value("prg_addr at $8000", prg_addr, 20'h00000);
        to_drive_point();
        cpu_addr = 16'hc000;
        #3;
        check_value("prg_addr at $c000", prg_addr, 20'h3c000);   // bank 15.
    endtask

    task automatic test_serial_load();
        logic [4:0] value;
        for (int idx = 0; idx < 4; idx++)
            write_reg(idx, 5'(next_random()));
        check_registers(8'h10);
        for (int m = 0; m < 4; m++) begin
            value = 5'(next_random());
            write_reg(0, {value[4], 2'(m), value[1:0]});
            write_reg(3, 5'(next_random()));
            for (int n = 0; n < samples; n++)
                check_translation();
        end
    endtask

    task automatic test_load_reset();
        write_reg(0, 5'b10001);
        cpu_write(16'h8000, 8'h01);
        cpu_write(16'h8000, 8'h00);
        cpu_write(16'ha000, 8'h80);   // abort after two bits.
        shadow_control = 5'b11101;
        check_registers(8'h10);
        write_reg(3, 5'(next_random()));
        check_registers(8'h10);
    endtask

    task automatic test_chr_mapping();
        logic [31:0] r;
        for (int mode = 0; mode < 2; mode++) begin
            for (int ram = 0; ram < 2; ram++) begin
                r = next_random();
                write_reg(0, {1'(mode), 2'b11, r[1:0]});
                write_reg(1, 5'(next_random()));
                write_reg(2, 5'(next_random()));
                chr_ram = 1'(ram);
                for (int n = 0; n < samples; n++) begin
                    to_drive_point();
                    r        = next_random();
                    ppu_addr = r[13:0];
                    ppu_rd   = r[20];
                    ppu_wr   = r[21];
                    #3;
                    check_value("chr_addr", chr_addr, expect_chr_addr(ppu_addr, chr_ram));
                    check_value("chr_we", chr_we, chr_ram && !ppu_wr);
                    check_value("chr_oe", chr_oe, !ppu_rd);
                    check_value("ciram_ce", ciram_ce, !ppu_addr[13]);
                end
            end
        end
        to_drive_point();
        chr_ram = 1'b0;
        ppu_rd  = 1'b1;
        ppu_wr  = 1'b1;
        for (int m = 0; m < 4; m++) begin
            write_reg(0, {3'b011, 2'(m)});
            for (int n = 0; n < samples / 2; n++)
                check_translation();
        end
        // 4k chr, fix-last prg, chr0 bit 4 set, chr1 bit 4 clear.
        write_reg(0, 5'b11100);
        write_reg(1, 5'b10011);
        write_reg(2, 5'b00101);
        write_reg(3, 5'b00010);
        to_drive_point();
        cpu_addr = 16'h8123;
        ppu_addr = 14'h0000;
        #3;
        check_value("prg_addr with outer bit set", prg_addr, 20'h48123);
        to_drive_point();
        ppu_addr = 14'h1000;
        #3;
        check_value("prg_addr with outer bit clear", prg_addr, 20'h08123);
    endtask

    task automatic test_work_ram();
        logic [15:0] a;
        for (int dis = 0; dis < 2; dis++) begin
            write_reg(3, {1'(dis), 4'b0110});
            for (int n = 0; n < samples / 2; n++) begin
                to_drive_point();
                a        = 16'h6000 | 16'(next_random() & 32'h1fff);
                cpu_addr = a;
                cpu_rw   = 1'(n % 2);
                #3;
                check_value("wram_ce", wram_ce, dis == 0);
                check_value("prg_oe", prg_oe, cpu_rw && dis == 0);
                check_value("prg_we", prg_we, !cpu_rw && dis == 0);
                if (dis == 0)
                    check_value("wram prg_addr", prg_addr, 20'(a[12:0]));
            end
        end
    endtask

    task automatic test_save_state_override();
        logic [4:0] value;
        for (int idx = 1; idx < 5; idx++) begin
            value = 5'(next_random());
            sst_write(3'(idx), value);
            case (idx)
                1:       shadow_control = value;
                2:       shadow_chr0    = value;
                3:       shadow_chr1    = value;
                default: shadow_prg     = value;
            endcase
            check_translation();
            check_registers(8'h10);
        end
        sst_write(mmc1_pkg::sst_shift, 5'b00100);
        check_registers(8'h04);
    endtask

    initial begin
        reset          = 1'b1;
        cpu_addr       = 16'h0000;
        cpu_rw         = 1'b1;
        cpu_data_in    = 8'h00;
        ppu_addr       = 14'h0000;
        ppu_rd         = 1'b1;
        ppu_wr         = 1'b1;
        chr_ram        = 1'b0;
        sst_enable     = 1'b0;
        sst_we         = 1'b0;
        sst_addr       = 3'd0;
        sst_data_in    = 8'h00;
        shadow_control = 5'b01100;   // fix-last, one-screen low.
        shadow_chr0    = 5'd0;
        shadow_chr1    = 5'd0;
        shadow_prg     = 5'd0;
        repeat (reset_cycles) @(posedge m2);
        #2;
        reset = 1'b0;
        test_reset_state();
        test_serial_load();
        test_load_reset();
        test_chr_mapping();
        test_work_ram();
        test_save_state_override();
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+tb
verilog/mmc1_pkg.sv
verilog/mmc1_regs.sv
verilog/mmc1_prg_map.sv
verilog/mmc1_chr_map.sv
verilog/mapper_mmc1.sv
tb/mapper_mmc1_tb.sv
